/* include/mxint_cast_cfg.svh */
`ifndef MXINT_CAST_CFG_SVH
`define MXINT_CAST_CFG_SVH

// Mantissas sharing one exponent.
`define MXC_BLOCK_SIZE 4

// Input format, Q1.7 mantissas.
`define MXC_IN_MAN_WIDTH 8
`define MXC_IN_MAN_FRAC 7
`define MXC_IN_EXP_WIDTH 5

// Output format, Q1.3 mantissas.
`define MXC_OUT_MAN_WIDTH 4
`define MXC_OUT_MAN_FRAC 3
`define MXC_OUT_EXP_WIDTH 5

// Holds a bit index of the largest magnitude, 128 included.
`define MXC_LOG2_WIDTH ($clog2(`MXC_IN_MAN_WIDTH) + 1)

`define MXC_FIFO_DEPTH 4

`endif

/* verilog/mxint_pkg.sv */
`include "mxint_cast_cfg.svh"

package mxint_pkg;

  // Input side.
  typedef logic signed [`MXC_IN_MAN_WIDTH-1:0] in_man_t;
  typedef logic signed [`MXC_IN_EXP_WIDTH-1:0] in_exp_t;

  // Output side.
  typedef logic signed [`MXC_OUT_MAN_WIDTH-1:0] out_man_t;
  typedef logic signed [`MXC_OUT_EXP_WIDTH-1:0] out_exp_t;

  typedef logic [`MXC_LOG2_WIDTH-1:0] log2_t;  // Floor log2 of max magnitude.

  typedef in_man_t in_blk_t [`MXC_BLOCK_SIZE-1:0];
  typedef out_man_t out_blk_t [`MXC_BLOCK_SIZE-1:0];

endpackage

/* verilog/mxint_block_if.sv */
`timescale 1ns/1ns

interface mxint_block_if;
  import mxint_pkg::*;

  logic    valid;
  logic    ready;
  in_blk_t mant;
  in_exp_t exp;       // Shared input exponent.
  log2_t   log2_max;  // Attached by the producer.

  modport src (
    output valid,
    output mant,
    output exp,
    output log2_max,
    input  ready
  );

  modport snk (
    input  valid,
    input  mant,
    input  exp,
    input  log2_max,
    output ready
  );

endinterface

/* verilog/mxint_max_log2.sv */
`timescale 1ns/1ns
`include "mxint_cast_cfg.svh"

module mxint_max_log2 (
  input  logic               clk,
  input  logic               rst,
  input  mxint_pkg::in_blk_t mdata_in,
  input  mxint_pkg::in_exp_t edata_in,
  input  logic               data_in_valid,
  output logic               data_in_ready,
  mxint_block_if.src         out
);
  import mxint_pkg::*;

  localparam int MAN_W = `MXC_IN_MAN_WIDTH;

  logic [MAN_W-1:0]                       mag_or;
  log2_t                                  log2_next;
  logic                                   load;
  logic [`MXC_BLOCK_SIZE*MAN_W-1:0]       mant_bits;

  // OR of magnitudes has the same top bit as the maximum.
  always_comb begin
    mag_or = '0;
    for (int i = 0; i < `MXC_BLOCK_SIZE; i++) begin
      if (mdata_in[i][MAN_W-1]) begin
        mag_or = mag_or | MAN_W'(-mdata_in[i]);  // -128 stays 8'h80.
      end else begin
        mag_or = mag_or | MAN_W'(mdata_in[i]);
      end
    end
  end

  always_comb begin
    log2_next = '0;  // All zero block gives 0.
    for (int b = 0; b < MAN_W; b++) begin
      if (mag_or[b]) begin
        log2_next = log2_t'(b);
      end
    end
  end

  assign data_in_ready = !out.valid || out.ready;
  assign load          = data_in_valid && data_in_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      out.valid <= 1'b0;
    end else if (load) begin
      out.valid <= 1'b1;
    end else if (out.ready) begin
      out.valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      out.mant     <= mdata_in;
      out.exp      <= edata_in;
      out.log2_max <= log2_next;
    end
  end

  assign mant_bits = {>>{out.mant}};

  // Held block must not change until the FIFO takes it.
  a_hold_stable: assert property (
    @(posedge clk) disable iff (rst)
    out.valid && !out.ready |=> out.valid && $stable(mant_bits) && $stable(out.exp)
      && $stable(out.log2_max)
  ) else $error("producer output changed while stalled");

endmodule

/* verilog/mxint_block_fifo.sv */
`timescale 1ns/1ns
`include "mxint_cast_cfg.svh"

module mxint_block_fifo #(
  parameter int DEPTH = `MXC_FIFO_DEPTH
) (
  input  logic       clk,
  input  logic       rst,
  mxint_block_if.snk in,
  mxint_block_if.src out
);
  import mxint_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);

  in_blk_t          mem_mant [DEPTH];
  in_exp_t          mem_exp  [DEPTH];
  log2_t            mem_log2 [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             wr;
  logic             rd;
  logic [`MXC_BLOCK_SIZE*`MXC_IN_MAN_WIDTH-1:0] head_bits;

  assign in.ready  = (count != DEPTH);
  assign out.valid = (count != 0);

  assign wr = in.valid && in.ready;
  assign rd = out.valid && out.ready;

  // Show-ahead head.
  assign out.mant     = mem_mant[rd_ptr];
  assign out.exp      = mem_exp[rd_ptr];
  assign out.log2_max = mem_log2[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr) begin
      mem_mant[wr_ptr] <= in.mant;
      mem_exp[wr_ptr]  <= in.exp;
      mem_log2[wr_ptr] <= in.log2_max;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr) begin
        wr_ptr <= wr_ptr + 1'b1;  // Wraps, depth is a power of two.
      end
      if (rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr, rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign head_bits = {>>{out.mant}};

  // Overflow or underflow drives the count out of range.
  a_count_range: assert property (
    @(posedge clk) disable iff (rst) count <= DEPTH
  ) else $error("fifo written while full or read while empty");

  // A write while full would overwrite the waiting head.
  a_head_stable: assert property (
    @(posedge clk) disable iff (rst)
    out.valid && !out.ready |=> out.valid && $stable(head_bits) && $stable(out.exp)
      && $stable(out.log2_max)
  ) else $error("fifo head changed while stalled");

endmodule

/* verilog/mxint_requant.sv */
`timescale 1ns/1ns
`include "mxint_cast_cfg.svh"

module mxint_requant (
  input  logic                clk,
  input  logic                rst,
  mxint_block_if.snk          in,
  output mxint_pkg::out_blk_t mdata_out,
  output mxint_pkg::out_exp_t edata_out,
  output logic                data_out_valid,
  input  logic                data_out_ready
);
  import mxint_pkg::*;

  // Wide enough for exponent plus log2 without loss.
  localparam int FULL_W = ((`MXC_IN_EXP_WIDTH > `MXC_OUT_EXP_WIDTH) ?
                           `MXC_IN_EXP_WIDTH : `MXC_OUT_EXP_WIDTH) + 2;
  localparam int WIDE_W = `MXC_IN_MAN_WIDTH + `MXC_OUT_MAN_WIDTH + 1;
  localparam int OUT_W  = `MXC_OUT_MAN_WIDTH;

  localparam logic signed [FULL_W-1:0] EXP_MAX =
    FULL_W'((1 << (`MXC_OUT_EXP_WIDTH - 1)) - 1);
  localparam logic signed [FULL_W-1:0] EXP_MIN =
    FULL_W'(-(1 << (`MXC_OUT_EXP_WIDTH - 1)));
  localparam logic signed [WIDE_W-1:0] MAN_MAX = WIDE_W'((1 << (OUT_W - 1)) - 1);
  localparam logic signed [WIDE_W-1:0] MAN_MIN = WIDE_W'(-(1 << (OUT_W - 1)));

  logic signed [FULL_W-1:0]       exp_full;
  logic signed [FULL_W-1:0]       exp_clamped;
  logic signed [FULL_W-1:0]       shift;
  out_blk_t                       mant_next;
  logic                           load;
  logic [`MXC_BLOCK_SIZE*OUT_W-1:0] mant_bits;

  // Shift, round half up, saturate one mantissa.
  function automatic out_man_t requant_lane(input in_man_t m,
                                            input logic signed [FULL_W-1:0] s);
    logic signed [WIDE_W-1:0] wide;
    int                       amt;
    wide = WIDE_W'(m);
    if (s > 0) begin
      amt = int'(s);
      if (amt > `MXC_IN_MAN_WIDTH) begin
        amt = `MXC_IN_MAN_WIDTH;  // Result is 0 past this point.
      end
      wide = (wide + (WIDE_W'(1) <<< (amt - 1))) >>> amt;
    end else begin
      amt = -int'(s);
      if (amt > OUT_W) begin
        amt = OUT_W;  // Any nonzero value saturates here.
      end
      wide = wide <<< amt;
    end
    if (wide > MAN_MAX) begin
      return out_man_t'(MAN_MAX);
    end else if (wide < MAN_MIN) begin
      return out_man_t'(MAN_MIN);
    end
    return out_man_t'(wide);
  endfunction

  always_comb begin
    exp_full = FULL_W'(in.exp) + FULL_W'(signed'({1'b0, in.log2_max})) + FULL_W'(1)
               - FULL_W'(`MXC_IN_MAN_FRAC);
    if (exp_full > EXP_MAX) begin
      exp_clamped = EXP_MAX;
    end else if (exp_full < EXP_MIN) begin
      exp_clamped = EXP_MIN;
    end else begin
      exp_clamped = exp_full;
    end
    shift = exp_clamped - FULL_W'(in.exp)
            + FULL_W'(`MXC_IN_MAN_FRAC - `MXC_OUT_MAN_FRAC);
  end

  always_comb begin
    for (int i = 0; i < `MXC_BLOCK_SIZE; i++) begin
      mant_next[i] = requant_lane(in.mant[i], shift);
    end
  end

  assign in.ready = !data_out_valid || data_out_ready;
  assign load     = in.valid && in.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      data_out_valid <= 1'b0;
    end else if (load) begin
      data_out_valid <= 1'b1;
    end else if (data_out_ready) begin
      data_out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      mdata_out <= mant_next;
      edata_out <= out_exp_t'(exp_clamped);
    end
  end

  assign mant_bits = {>>{mdata_out}};

  a_out_stable: assert property (
    @(posedge clk) disable iff (rst)
    data_out_valid && !data_out_ready |=> data_out_valid && $stable(mant_bits)
      && $stable(edata_out)
  ) else $error("output block changed while stalled");

endmodule

/* verilog/mxint_cast.sv */
`timescale 1ns/1ns
`include "mxint_cast_cfg.svh"

module mxint_cast (
  input  logic                clk,
  input  logic                rst,
  input  mxint_pkg::in_blk_t  mdata_in,
  input  mxint_pkg::in_exp_t  edata_in,
  input  logic                data_in_valid,
  output logic                data_in_ready,
  output mxint_pkg::out_blk_t mdata_out,
  output mxint_pkg::out_exp_t edata_out,
  output logic                data_out_valid,
  input  logic                data_out_ready
);

  mxint_block_if max_if ();   // Producer to FIFO.
  mxint_block_if fifo_if ();  // FIFO head to consumer.

  mxint_max_log2 u_max_log2 (
    .clk           (clk),
    .rst           (rst),
    .mdata_in      (mdata_in),
    .edata_in      (edata_in),
    .data_in_valid (data_in_valid),
    .data_in_ready (data_in_ready),
    .out           (max_if.src)
  );

  mxint_block_fifo #(
    .DEPTH (`MXC_FIFO_DEPTH)
  ) u_block_fifo (
    .clk (clk),
    .rst (rst),
    .in  (max_if.snk),
    .out (fifo_if.src)
  );

  mxint_requant u_requant (
    .clk            (clk),
    .rst            (rst),
    .in             (fifo_if.snk),
    .mdata_out      (mdata_out),
    .edata_out      (edata_out),
    .data_out_valid (data_out_valid),
    .data_out_ready (data_out_ready)
  );

endmodule

/* verification/tb_mxint_cast.sv */
`timescale 1ns/1ns
`include "mxint_cast_cfg.svh"

module tb_mxint_cast;
  import mxint_pkg::*;

  localparam int BS    = `MXC_BLOCK_SIZE;
  localparam int MW    = `MXC_IN_MAN_WIDTH;
  localparam int OW    = `MXC_OUT_MAN_WIDTH;
  localparam int EW    = `MXC_IN_EXP_WIDTH;
  localparam int OEW   = `MXC_OUT_EXP_WIDTH;
  localparam int BLK_W = BS * MW + EW;
  localparam int RES_W = BS * OW + OEW;

  localparam int RESET_BLOCKS  = 6;
  localparam int RANDOM_BLOCKS = 300;
  localparam int CLAMP_BLOCKS  = 22;
  localparam int EDGE_BLOCKS   = 9;
  localparam int STALL_BLOCKS  = 60;
  localparam int TOTAL_BLOCKS  = RESET_BLOCKS + RANDOM_BLOCKS + CLAMP_BLOCKS + EDGE_BLOCKS
                                 + STALL_BLOCKS;
  localparam int WATCHDOG_CYCLES = 12 * TOTAL_BLOCKS + 200;
  localparam int DRAIN_CYCLES    = 400;  // Far beyond the longest stall stretch.

  logic     clk;
  logic     rst;
  in_blk_t  mdata_in;
  in_exp_t  edata_in;
  logic     data_in_valid;
  logic     data_in_ready;
  out_blk_t mdata_out;
  out_exp_t edata_out;
  logic     data_out_valid;
  logic     data_out_ready;

  logic [BLK_W-1:0] pend_q [$];  // Blocks waiting to be driven.
  logic [RES_W-1:0] exp_q [$];   // Expected results in order.
  logic [31:0]      stim_state;
  logic [31:0]      rdy_state;
  logic [RES_W-1:0] held_out;
  logic             stalled;
  int               ready_pct;
  int               long_stalls;
  int               stall_left;
  int               errors;
  int               checks;
  int               accepted;

  mxint_cast UUT (
    .clk            (clk),
    .rst            (rst),
    .mdata_in       (mdata_in),
    .edata_in       (edata_in),
    .data_in_valid  (data_in_valid),
    .data_in_ready  (data_in_ready),
    .mdata_out      (mdata_out),
    .edata_out      (edata_out),
    .data_out_valid (data_out_valid),
    .data_out_ready (data_out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function logic [31:0] rand_stim();
    stim_state = xorshift(stim_state);
    return stim_state;
  endfunction

  task check_val(input logic [63:0] actual, input logic [63:0] expected, input string what);
    checks = checks + 1;
    if (actual !== expected) begin
      errors = errors + 1;
      $display("mismatch at %0t: %s, got %h expected %h", $time, what, actual, expected);
    end
  endtask

  // Reference cast following the block rules.
  function automatic logic [RES_W-1:0] model_block(input logic [BLK_W-1:0] blk);
    int          m [BS];
    int          e;
    int          mag;
    int          max_mag;
    int          l;
    int          ne;
    int          s;
    int          r;
    logic [RES_W-1:0] res;
    e = $signed(blk[BLK_W-1 -: EW]);
    max_mag = 0;
    for (int i = 0; i < BS; i++) begin
      m[i] = $signed(blk[i*MW +: MW]);
      mag = (m[i] < 0) ? -m[i] : m[i];
      if (mag > max_mag) begin
        max_mag = mag;
      end
    end
    l = 0;
    for (int b = 0; b <= MW; b++) begin
      if ((max_mag >> b) != 0) begin
        l = b;
      end
    end
    ne = e + l + 1 - `MXC_IN_MAN_FRAC;
    if (ne > 15) ne = 15;
    if (ne < -16) ne = -16;
    s = ne - e + (`MXC_IN_MAN_FRAC - `MXC_OUT_MAN_FRAC);
    res[RES_W-1 -: OEW] = ne[OEW-1:0];
    for (int i = 0; i < BS; i++) begin
      if (s > 0) begin
        r = (m[i] + (1 << (s - 1))) >>> s;  // Round half up.
      end else begin
        r = m[i] * (1 << -s);
      end
      if (r > 7) r = 7;
      if (r < -8) r = -8;
      res[i*OW +: OW] = r[OW-1:0];
    end
    return res;
  endfunction

  function automatic logic [BLK_W-1:0] make_block(input int e, input int m0, input int m1,
                                                  input int m2, input int m3);
    return {e[EW-1:0], m3[MW-1:0], m2[MW-1:0], m1[MW-1:0], m0[MW-1:0]};
  endfunction

  function automatic logic [BLK_W-1:0] rand_block();
    logic [BLK_W-1:0] blk;
    logic [31:0]      r;
    logic [2:0]       sh;
    r = rand_stim();
    blk[BLK_W-1 -: EW] = r[EW-1:0];
    sh = r[10:8];  // Spreads the log2 values.
    for (int i = 0; i < BS; i++) begin
      r = rand_stim();
      blk[i*MW +: MW] = $signed(r[7:0]) >>> sh;
    end
    return blk;
  endfunction

  function automatic logic [BLK_W-1:0] in_word();
    logic [BLK_W-1:0] w;
    w[BLK_W-1 -: EW] = edata_in;
    for (int i = 0; i < BS; i++) begin
      w[i*MW +: MW] = mdata_in[i];
    end
    return w;
  endfunction

  function automatic logic [RES_W-1:0] out_word();
    logic [RES_W-1:0] w;
    w[RES_W-1 -: OEW] = edata_out;
    for (int i = 0; i < BS; i++) begin
      w[i*OW +: OW] = mdata_out[i];
    end
    return w;
  endfunction

  task automatic drive_block(input logic [BLK_W-1:0] blk);
    for (int i = 0; i < BS; i++) begin
      mdata_in[i] <= blk[i*MW +: MW];
    end
    edata_in <= blk[BLK_W-1 -: EW];
  endtask

  // Presents queued blocks, holding each one until it is taken.
  task automatic drive_pending(input int valid_pct);
    logic busy;
    busy = 1'b0;
    while (pend_q.size() > 0 || busy) begin
      @(posedge clk);
      if (busy && data_in_ready) begin
        busy = 1'b0;
      end
      if (!busy) begin
        if (pend_q.size() > 0 && int'(rand_stim() % 100) < valid_pct) begin
          drive_block(pend_q.pop_front());
          busy = 1'b1;
        end
        data_in_valid <= busy;
      end
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() > 0 && waited < DRAIN_CYCLES) begin
      @(posedge clk);
      waited = waited + 1;
    end
    repeat (2) @(posedge clk);
  endtask

  always @(posedge clk) begin
    rdy_state = xorshift(rdy_state);
    if (stall_left > 0) begin
      stall_left = stall_left - 1;
      data_out_ready <= 1'b0;
    end else if (long_stalls != 0 && rdy_state[7:4] == 4'd0) begin
      stall_left = 10 + int'(rdy_state[12:8]);  // Long stretch of back-pressure.
      data_out_ready <= 1'b0;
    end else begin
      data_out_ready <= int'(rdy_state[31:16] % 100) < ready_pct;
    end
  end

  // Scoreboard and stall monitor.
  always @(posedge clk) begin
    if (rst) begin
      stalled = 1'b0;
    end else begin
      if (stalled) begin
        check_val(data_out_valid, 1'b1, "data_out_valid dropped while stalled");
        check_val(out_word(), held_out, "output changed while stalled");
      end
      stalled = data_out_valid && !data_out_ready;
      held_out = out_word();
      if (data_in_valid && data_in_ready) begin
        exp_q.push_back(model_block(in_word()));
      end
      if (data_out_valid && data_out_ready) begin
        if (exp_q.size() == 0) begin
          errors = errors + 1;
          $display("output block at %0t arrived with no block expected", $time);
        end else begin
          check_val(out_word(), exp_q.pop_front(), "output block");
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * 8);
    $display("run timed out after %0d cycles with %0d errors", WATCHDOG_CYCLES, errors);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    stim_state = 32'd29;
    rdy_state = xorshift(32'd29);
    rst = 1'b1;
    data_in_valid = 1'b0;
    data_out_ready = 1'b0;
    edata_in = '0;
    for (int i = 0; i < BS; i++) begin
      mdata_in[i] = '0;
    end
    ready_pct = 0;
    long_stalls = 0;
    stall_left = 0;
    errors = 0;
    checks = 0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    // Output stalled, six blocks fit before input stalls.
    @(posedge clk);
    check_val(data_out_valid, 1'b0, "data_out_valid after reset");
    accepted = 0;
    drive_block(rand_block());
    data_in_valid <= 1'b1;
    for (int c = 0; c < 12; c++) begin
      @(posedge clk);
      check_val(data_in_ready, accepted < RESET_BLOCKS, "data_in_ready with output stalled");
      if (data_in_valid && data_in_ready) begin
        accepted = accepted + 1;
        if (accepted < RESET_BLOCKS) begin
          drive_block(rand_block());
        end else begin
          data_in_valid <= 1'b0;
        end
      end
    end
    ready_pct = 70;
    wait_drain();

    for (int n = 0; n < RANDOM_BLOCKS; n++) begin
      pend_q.push_back(rand_block());
    end
    drive_pending(70);
    wait_drain();

    // Extreme exponents.
    pend_q.push_back(make_block(15, 127, -128, 100, -100));
    pend_q.push_back(make_block(-16, 1, -1, 2, 0));
    for (int n = 0; n < (CLAMP_BLOCKS - 2) / 2; n++) begin
      logic [BLK_W-1:0] hi;
      logic [BLK_W-1:0] lo;
      logic [31:0]      r;
      hi[BLK_W-1 -: EW] = 5'd15;
      lo[BLK_W-1 -: EW] = 5'h10;
      for (int i = 0; i < BS; i++) begin
        r = rand_stim();
        hi[i*MW +: MW] = r[8] ? -(8'h40 | r[5:0]) : (8'h40 | r[5:0]);
        lo[i*MW +: MW] = 8'($signed(r[18:16]));
      end
      hi[r[21:20]*MW +: MW] = 8'h80;  // Magnitude 128 forces the top clamp.
      pend_q.push_back(hi);
      pend_q.push_back(lo);
    end
    drive_pending(100);
    wait_drain();

    pend_q.push_back(make_block(0, 0, 0, 0, 0));
    pend_q.push_back(make_block(-16, 0, 0, 0, 0));
    pend_q.push_back(make_block(15, 0, 0, 0, 0));
    pend_q.push_back(make_block(0, -128, 0, 0, 0));
    pend_q.push_back(make_block(-5, -128, -128, -128, -128));
    pend_q.push_back(make_block(0, 8, 3, -3, -5));   // Ties at shift 1.
    pend_q.push_back(make_block(3, 16, 2, -2, 6));   // Ties at shift 2.
    pend_q.push_back(make_block(-2, 1, -1, 0, 1));   // Left shift.
    pend_q.push_back(make_block(7, -128, 64, -64, 127));
    drive_pending(100);
    wait_drain();

    long_stalls = 1;
    ready_pct = 50;
    for (int n = 0; n < STALL_BLOCKS; n++) begin
      pend_q.push_back(rand_block());
    end
    drive_pending(90);
    wait_drain();
    long_stalls = 0;
    ready_pct = 100;

    repeat (4) @(posedge clk);
    if (exp_q.size() != 0) begin
      errors = errors + 1;
      $display("scoreboard still holds %0d blocks that never came out", exp_q.size());
    end
    $display("%0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+include
verilog/mxint_pkg.sv
verilog/mxint_block_if.sv
verilog/mxint_max_log2.sv
verilog/mxint_block_fifo.sv
verilog/mxint_requant.sv
verilog/mxint_cast.sv
verification/tb_mxint_cast.sv
